// File: project.f
logic/decode_pkg.sv
logic/inst_byte_queue.sv
logic/length_decode.sv
logic/imm_disp_separate.sv
logic/inst_decode_top.sv
tests/inst_decode_props.sv
tests/inst_decode_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f project.f --top-module inst_decode_tb \
   -o inst_decode_sim &&
./obj_dir/inst_decode_sim ||
{ echo "simulation failed"; exit 1; }

// File: tests/inst_decode_tb.sv
`timescale 1ns/1ps

module inst_decode_tb import decode_pkg::*; ();

   typedef struct packed {
      logic [7:0]        opcode;
      logic [7:0]        modrm;
      logic              has_modrm;
      logic              illegal;
      logic [LEN_W-1:0]  length;
      op_size_e          size;
      logic [IMM_W-1:0]  imm;
      logic [DISP_W-1:0] disp;
   } exp_t;

   logic                     clk;
   logic                     rst_n;
   logic                     fetch_valid;
   logic [8*FETCH_BYTES-1:0] fetch_bytes;
   logic                     fetch_ready;
   logic                     out_ready;
   logic                     out_valid;
   logic [7:0]               out_opcode;
   logic [7:0]               out_modrm;
   logic                     out_has_modrm;
   logic                     out_illegal;
   logic [LEN_W-1:0]         out_length;
   op_size_e                 out_size;
   logic [IMM_W-1:0]         out_imm;
   logic [DISP_W-1:0]        out_disp;

   logic [7:0]               stream_q[$];
   logic [8*FETCH_BYTES-1:0] beat_q[$];
   exp_t                     exp_q[$];

   logic [7:0] legal_ops [9] = '{OPC_ADD_AL_IB, OPC_ADD_EAX_IZ, OPC_GRP1_EB_IB, OPC_GRP1_EV_IZ,
                                 OPC_GRP1_EV_IB, OPC_ADD_EV_GV, OPC_ADD_GV_EV, OPC_JMP_FAR,
                                 OPC_NOP};

   inst_decode_top #(
      .QUEUE_BYTES (32)
   ) u_inst_decode_top (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_valid   (fetch_valid),
      .fetch_bytes   (fetch_bytes),
      .fetch_ready   (fetch_ready),
      .out_ready     (out_ready),
      .out_valid     (out_valid),
      .out_opcode    (out_opcode),
      .out_modrm     (out_modrm),
      .out_has_modrm (out_has_modrm),
      .out_illegal   (out_illegal),
      .out_length    (out_length),
      .out_size      (out_size),
      .out_imm       (out_imm),
      .out_disp      (out_disp)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   function automatic bit is_known(input logic [7:0] b);
      return b inside {OPC_ADD_AL_IB, OPC_ADD_EAX_IZ, OPC_GRP1_EB_IB, OPC_GRP1_EV_IZ,
                       OPC_GRP1_EV_IB, OPC_ADD_EV_GV, OPC_ADD_GV_EV, OPC_JMP_FAR,
                       OPC_NOP, PFX_OPSIZE};
   endfunction

   // reference model, one instruction into the byte stream and its expected result
   task automatic add_instruction(input bit bad);
      exp_t       e;
      logic [7:0] op;
      logic [7:0] b;
      bit         pfx;
      int         n_disp;
      int         n_imm;
      int         start;
      logic [1:0] mode;
      logic [2:0] rm;
      logic [2:0] base;
      e = '0;
      n_disp = 0;
      n_imm = 0;
      start = stream_q.size();
      if (bad) begin
         do begin
            op = 8'($urandom);
         end while (is_known(op));
         stream_q.push_back(op);
         e.opcode = op;
         e.illegal = 1'b1;
         e.length = LEN_W'(1);
         e.size = SIZE_32;
         exp_q.push_back(e);
         return;
      end
      op = legal_ops[$urandom % 9];
      pfx = 1'($urandom);
      if (pfx) stream_q.push_back(PFX_OPSIZE);
      stream_q.push_back(op);
      e.opcode = op;
      if (op inside {OPC_GRP1_EB_IB, OPC_GRP1_EV_IZ, OPC_GRP1_EV_IB, OPC_ADD_EV_GV,
                     OPC_ADD_GV_EV}) begin
         e.has_modrm = 1'b1;
         e.modrm = 8'($urandom);
         stream_q.push_back(e.modrm);
         mode = e.modrm[7:6];
         rm = e.modrm[2:0];
         base = 3'b000;
         if (mode != 2'b11 && rm == 3'b100) begin
            b = 8'($urandom);
            stream_q.push_back(b);
            base = b[2:0];
         end
         if (mode == 2'b01) n_disp = 1;
         else if (mode == 2'b10) n_disp = 4;
         else if (mode == 2'b00 && (rm == 3'b101 || (rm == 3'b100 && base == 3'b101)))
            n_disp = 4;
      end
      for (int i = 0; i < n_disp; i++) begin
         b = 8'($urandom);
         stream_q.push_back(b);
         e.disp[8*i +: 8] = b;
      end
      if (n_disp == 1) e.disp = {{24{e.disp[7]}}, e.disp[7:0]};
      // operand size from prefix and opcode form
      if (op == OPC_ADD_AL_IB || op == OPC_GRP1_EB_IB) e.size = SIZE_8;
      else if (op == OPC_JMP_FAR) e.size = pfx ? SIZE_32 : SIZE_48;
      else e.size = pfx ? SIZE_16 : SIZE_32;
      if (op inside {OPC_ADD_AL_IB, OPC_GRP1_EB_IB, OPC_GRP1_EV_IB}) n_imm = 1;
      else if (op inside {OPC_ADD_EAX_IZ, OPC_GRP1_EV_IZ}) n_imm = pfx ? 2 : 4;
      else if (op == OPC_JMP_FAR) n_imm = pfx ? 4 : 6;
      for (int i = 0; i < n_imm; i++) begin
         b = 8'($urandom);
         stream_q.push_back(b);
         e.imm[8*i +: 8] = b;
      end
      if (n_imm == 1 && e.size == SIZE_16) e.imm = {32'h0, {8{e.imm[7]}}, e.imm[7:0]};
      if (n_imm == 1 && e.size == SIZE_32) e.imm = {16'h0, {24{e.imm[7]}}, e.imm[7:0]};
      e.length = LEN_W'(stream_q.size() - start);
      exp_q.push_back(e);
   endtask

   task automatic add_padding_nop();
      exp_t e;
      e = '0;
      stream_q.push_back(OPC_NOP);
      e.opcode = OPC_NOP;
      e.length = LEN_W'(1);
      e.size = SIZE_32;
      exp_q.push_back(e);
   endtask

   task automatic check_field(input string field, input int idx, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
      assert (exp_val == act_val) else
         stop_with_error($sformatf("ERR %s of instruction %0d: expected %0h, actual %0h",
                                   field, idx, exp_val, act_val));
   endtask

   task automatic compare_output(input int idx, input exp_t e);
      check_field("opcode", idx, 64'(e.opcode), 64'(out_opcode));
      check_field("modrm", idx, 64'(e.modrm), 64'(out_modrm));
      check_field("has_modrm", idx, 64'(e.has_modrm), 64'(out_has_modrm));
      check_field("illegal", idx, 64'(e.illegal), 64'(out_illegal));
      check_field("length", idx, 64'(e.length), 64'(out_length));
      check_field("size", idx, 64'(e.size), 64'(out_size));
      check_field("imm", idx, 64'(e.imm), 64'(out_imm));
      check_field("disp", idx, 64'(e.disp), 64'(out_disp));
   endtask

   initial begin
      logic [8*FETCH_BYTES-1:0] beat;
      int  cycles;
      int  limit;
      int  n_out;
      int  beat_idx;
      int  drain;
      bit  saw_full;
      rst_n = 1'b0;
      fetch_valid = 1'b0;
      fetch_bytes = '0;
      out_ready = 1'b0;
      n_out = 0;
      beat_idx = 0;
      drain = 0;
      saw_full = 1'b0;
      void'($urandom(32'h4e9a8d28));
      for (int i = 0; i < 400; i++) add_instruction(($urandom % 20) == 0);
      // stream ends on a whole beat
      while (stream_q.size() % FETCH_BYTES != 0) add_padding_nop();
      for (int i = 0; i < stream_q.size(); i += FETCH_BYTES) begin
         for (int j = 0; j < FETCH_BYTES; j++) beat[8*j +: 8] = stream_q[i+j];
         beat_q.push_back(beat);
      end
      limit = 4 * (stream_q.size() + exp_q.size()) + 16;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (!out_valid && fetch_ready) else
         stop_with_error("DUT not idle after reset, out_valid high or fetch_ready low");
      cycles = 16;
      while (exp_q.size() > 0 || drain < 8) begin
         if (out_valid && out_ready) begin
            assert (exp_q.size() > 0) else
               stop_with_error("DUT produced more instructions than were sent");
            compare_output(n_out, exp_q.pop_front());
            n_out++;
         end
         if (fetch_valid && fetch_ready) beat_idx++;
         if (!fetch_ready) saw_full = 1'b1;
         if (beat_idx < beat_q.size() && ($urandom % 4) != 0) begin
            fetch_valid <= 1'b1;
            fetch_bytes <= beat_q[beat_idx];
         end else begin
            fetch_valid <= 1'b0;
         end
         // a long stall every 96 cycles lets the queue fill up
         out_ready <= (cycles % 96 >= 14) && (($urandom % 3) != 0);
         if (exp_q.size() == 0) drain++;
         cycles++;
         if (cycles >= limit) stop_with_error("timeout, the decoder hung before the stream ended");
         @(posedge clk);
      end
      if (saw_full) begin
         $display("test passed");
         $finish;
      end else begin
         stop_with_error("fetch_ready never went low while the output was stalled");
      end
   end

endmodule

// File: tests/inst_decode_props.sv
`timescale 1ns/1ps

module inst_decode_props import decode_pkg::*; (
   input logic              clk,
   input logic              rst_n,
   input logic              out_valid,
   input logic              out_ready,
   input logic [7:0]        out_opcode,
   input logic [7:0]        out_modrm,
   input logic              out_has_modrm,
   input logic              out_illegal,
   input logic [LEN_W-1:0]  out_length,
   input op_size_e          out_size,
   input logic [IMM_W-1:0]  out_imm,
   input logic [DISP_W-1:0] out_disp
);

   // stalled output keeps its valid and its payload
   hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable({out_opcode, out_modrm, out_has_modrm,
         out_illegal, out_length, out_size, out_imm, out_disp}))
      else $error("decoded output changed while out_ready was low");

   length_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> out_length >= LEN_W'(1) && out_length <= LEN_W'(MAX_INST_BYTES))
      else $error("out_length outside 1 to %0d", MAX_INST_BYTES);

   idle_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
      else $error("out_valid high in the cycle after reset");

endmodule

bind inst_decode_top inst_decode_props u_props (
   .clk           (clk),
   .rst_n         (rst_n),
   .out_valid     (out_valid),
   .out_ready     (out_ready),
   .out_opcode    (out_opcode),
   .out_modrm     (out_modrm),
   .out_has_modrm (out_has_modrm),
   .out_illegal   (out_illegal),
   .out_length    (out_length),
   .out_size      (out_size),
   .out_imm       (out_imm),
   .out_disp      (out_disp)
);

// File: logic/inst_decode_top.sv
`timescale 1ns/1ps

module inst_decode_top import decode_pkg::*; #(
   parameter int QUEUE_BYTES = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     fetch_valid,
   input  logic [8*FETCH_BYTES-1:0] fetch_bytes,
   output logic                     fetch_ready,
   input  logic                     out_ready,
   output logic                     out_valid,
   output logic [7:0]               out_opcode,
   output logic [7:0]               out_modrm,
   output logic                     out_has_modrm,
   output logic                     out_illegal,
   output logic [LEN_W-1:0]         out_length,
   output op_size_e                 out_size,
   output logic [IMM_W-1:0]         out_imm,
   output logic [DISP_W-1:0]        out_disp
);

   logic [8*WINDOW_BYTES-1:0] head_window;
   logic [CNT_W-1:0]          head_count;
   logic                      pop;
   logic [LEN_W-1:0]          pop_len;
   logic                      dec_valid;
   logic                      dec_ready;
   logic [7:0]                dec_opcode;
   logic [7:0]                dec_modrm;
   logic                      dec_has_modrm;
   logic                      dec_illegal;
   logic [LEN_W-1:0]          dec_length;
   op_size_e                  dec_size;
   logic [FCNT_W-1:0]         dec_disp_bytes;
   logic [FCNT_W-1:0]         dec_imm_bytes;
   logic [FIELD_W-1:0]        dec_field_bytes;

   inst_byte_queue #(
      .QUEUE_BYTES (QUEUE_BYTES)
   ) u_queue (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_bytes (fetch_bytes),
      .fetch_ready (fetch_ready),
      .head_window (head_window),
      .head_count  (head_count),
      .pop         (pop),
      .pop_len     (pop_len)
   );

   // combinational, pops on the separator handshake
   length_decode u_length (
      .head_window     (head_window),
      .head_count      (head_count),
      .dec_ready       (dec_ready),
      .pop             (pop),
      .pop_len         (pop_len),
      .dec_valid       (dec_valid),
      .dec_opcode      (dec_opcode),
      .dec_modrm       (dec_modrm),
      .dec_has_modrm   (dec_has_modrm),
      .dec_illegal     (dec_illegal),
      .dec_length      (dec_length),
      .dec_size        (dec_size),
      .dec_disp_bytes  (dec_disp_bytes),
      .dec_imm_bytes   (dec_imm_bytes),
      .dec_field_bytes (dec_field_bytes)
   );

   imm_disp_separate u_separate (
      .clk             (clk),
      .rst_n           (rst_n),
      .dec_valid       (dec_valid),
      .dec_opcode      (dec_opcode),
      .dec_modrm       (dec_modrm),
      .dec_has_modrm   (dec_has_modrm),
      .dec_illegal     (dec_illegal),
      .dec_length      (dec_length),
      .dec_size        (dec_size),
      .dec_disp_bytes  (dec_disp_bytes),
      .dec_imm_bytes   (dec_imm_bytes),
      .dec_field_bytes (dec_field_bytes),
      .out_ready       (out_ready),
      .dec_ready       (dec_ready),
      .out_valid       (out_valid),
      .out_opcode      (out_opcode),
      .out_modrm       (out_modrm),
      .out_has_modrm   (out_has_modrm),
      .out_illegal     (out_illegal),
      .out_length      (out_length),
      .out_size        (out_size),
      .out_imm         (out_imm),
      .out_disp        (out_disp)
   );

endmodule

// File: logic/imm_disp_separate.sv
`timescale 1ns/1ps

module imm_disp_separate import decode_pkg::*; (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                dec_valid,
   input  logic [7:0]          dec_opcode,
   input  logic [7:0]          dec_modrm,
   input  logic                dec_has_modrm,
   input  logic                dec_illegal,
   input  logic [LEN_W-1:0]    dec_length,
   input  op_size_e            dec_size,
   input  logic [FCNT_W-1:0]   dec_disp_bytes,
   input  logic [FCNT_W-1:0]   dec_imm_bytes,
   input  logic [FIELD_W-1:0]  dec_field_bytes,
   input  logic                out_ready,
   output logic                dec_ready,
   output logic                out_valid,
   output logic [7:0]          out_opcode,
   output logic [7:0]          out_modrm,
   output logic                out_has_modrm,
   output logic                out_illegal,
   output logic [LEN_W-1:0]    out_length,
   output op_size_e            out_size,
   output logic [IMM_W-1:0]    out_imm,
   output logic [DISP_W-1:0]   out_disp
);

   logic              load;
   logic [IMM_W-1:0]  imm_raw;
   logic [IMM_W-1:0]  imm_mask;
   logic [IMM_W-1:0]  imm_ext;
   logic [DISP_W-1:0] disp_raw;
   logic [DISP_W-1:0] disp_mask;
   logic [DISP_W-1:0] disp_ext;

   // register empty or draining this cycle
   assign dec_ready = !out_valid || out_ready;
   assign load      = dec_valid && dec_ready;

   // immediate starts right after the displacement bytes
   assign imm_raw  = IMM_W'(dec_field_bytes >> {dec_disp_bytes, 3'b000});
   assign disp_raw = dec_field_bytes[DISP_W-1:0];

   // keep only the bytes that belong to each field
   assign imm_mask  = ~({IMM_W{1'b1}} << {dec_imm_bytes, 3'b000});
   assign disp_mask = ~({DISP_W{1'b1}} << {dec_disp_bytes, 3'b000});

   // disp8 always extends to the full displacement width
   assign disp_ext = (dec_disp_bytes == FCNT_W'(1)) ? {{(DISP_W-8){disp_raw[7]}}, 8'h00} : '0;

   // imm8 extends to the operand size, byte operands stay zero-extended
   always_comb begin
      imm_ext = '0;
      if (dec_imm_bytes == FCNT_W'(1)) begin
         case (dec_size)
            SIZE_16: imm_ext = {{(IMM_W-16){1'b0}}, {8{imm_raw[7]}}, 8'h00};
            SIZE_32: imm_ext = {{(IMM_W-32){1'b0}}, {24{imm_raw[7]}}, 8'h00};
            default: imm_ext = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // payload only changes on a transfer, so it holds under back-pressure
   always_ff @(posedge clk) begin
      if (load) begin
         out_opcode    <= dec_opcode;
         out_modrm     <= dec_modrm;
         out_has_modrm <= dec_has_modrm;
         out_illegal   <= dec_illegal;
         out_length    <= dec_length;
         out_size      <= dec_size;
         out_imm       <= (imm_raw & imm_mask) | imm_ext;
         out_disp      <= (disp_raw & disp_mask) | disp_ext;
      end
   end

endmodule

// File: logic/length_decode.sv
`timescale 1ns/1ps

module length_decode import decode_pkg::*; (
   input  logic [8*WINDOW_BYTES-1:0] head_window,
   input  logic [CNT_W-1:0]          head_count,
   input  logic                      dec_ready,
   output logic                      pop,
   output logic [LEN_W-1:0]          pop_len,
   output logic                      dec_valid,
   output logic [7:0]                dec_opcode,
   output logic [7:0]                dec_modrm,
   output logic                      dec_has_modrm,
   output logic                      dec_illegal,
   output logic [LEN_W-1:0]          dec_length,
   output op_size_e                  dec_size,
   output logic [FCNT_W-1:0]         dec_disp_bytes,
   output logic [FCNT_W-1:0]         dec_imm_bytes,
   output logic [FIELD_W-1:0]        dec_field_bytes
);

   typedef enum logic [1:0] {
      IMM_NONE,
      IMM_B,
      IMM_Z,
      IMM_FAR
   } imm_class_e;

   logic              has_pfx;
   logic [7:0]        opc;
   logic [7:0]        modrm;
   logic [7:0]        sib;
   logic [1:0]        mode;
   logic [2:0]        rm;
   logic              use_modrm;
   logic              byte_op;
   logic              illegal;
   logic              has_sib;
   imm_class_e        imm_class;
   logic [FCNT_W-1:0] disp_bytes;
   logic [FCNT_W-1:0] imm_bytes;
   logic [2:0]        field_ofs;
   logic [LEN_W-1:0]  length;
   logic [LEN_W-1:0]  need_bytes;
   op_size_e          size;

   // at most one prefix, so everything after it shifts by one byte
   assign has_pfx = head_window[7:0] == PFX_OPSIZE;
   assign opc     = has_pfx ? head_window[15:8]  : head_window[7:0];
   assign modrm   = has_pfx ? head_window[23:16] : head_window[15:8];
   assign sib     = has_pfx ? head_window[31:24] : head_window[23:16];

   assign mode = modrm[7:6];
   assign rm   = modrm[2:0];

   // opcode class lookup
   always_comb begin
      use_modrm = 1'b0;
      byte_op   = 1'b0;
      illegal   = 1'b0;
      imm_class = IMM_NONE;
      case (opc)
         OPC_ADD_AL_IB: begin
            byte_op   = 1'b1;
            imm_class = IMM_B;
         end
         OPC_GRP1_EB_IB: begin
            use_modrm = 1'b1;
            byte_op   = 1'b1;
            imm_class = IMM_B;
         end
         OPC_ADD_EAX_IZ: imm_class = IMM_Z;
         OPC_GRP1_EV_IZ: begin
            use_modrm = 1'b1;
            imm_class = IMM_Z;
         end
         OPC_GRP1_EV_IB: begin
            use_modrm = 1'b1;
            imm_class = IMM_B;
         end
         OPC_ADD_EV_GV, OPC_ADD_GV_EV: use_modrm = 1'b1;
         OPC_JMP_FAR: imm_class = IMM_FAR;
         OPC_NOP: illegal = 1'b0;
         default: illegal = 1'b1;
      endcase
   end

   // sib only with a memory operand and rm 100
   assign has_sib = use_modrm && (mode != 2'b11) && (rm == 3'b100);

   always_comb begin
      disp_bytes = '0;
      if (use_modrm) begin
         case (mode)
            2'b01: disp_bytes = FCNT_W'(1);
            2'b10: disp_bytes = FCNT_W'(4);
            2'b00: begin
               // disp32 with no base register
               if (rm == 3'b101 || (has_sib && sib[2:0] == 3'b101)) begin
                  disp_bytes = FCNT_W'(4);
               end
            end
            default: disp_bytes = '0;
         endcase
      end
   end

   always_comb begin
      case (imm_class)
         IMM_B:   imm_bytes = FCNT_W'(1);
         IMM_Z:   imm_bytes = has_pfx ? FCNT_W'(2) : FCNT_W'(4);
         IMM_FAR: imm_bytes = has_pfx ? FCNT_W'(4) : FCNT_W'(6);
         default: imm_bytes = '0;
      endcase
   end

   // illegal opcodes keep the prefix-based size
   always_comb begin
      if (byte_op) begin
         size = SIZE_8;
      end else if (imm_class == IMM_FAR) begin
         size = has_pfx ? SIZE_32 : SIZE_48;
      end else begin
         size = has_pfx ? SIZE_16 : SIZE_32;
      end
   end

   // first displacement byte sits right after opcode, modrm and sib
   assign field_ofs = 3'(has_pfx) + 3'd1 + 3'(use_modrm) + 3'(has_sib);

   assign length = illegal ? LEN_W'(1)
                           : LEN_W'(field_ofs) + LEN_W'(disp_bytes) + LEN_W'(imm_bytes);

   // an illegal opcode behind a prefix still needs its opcode byte present
   assign need_bytes = illegal ? LEN_W'(field_ofs) : length;

   assign dec_valid = CNT_W'(need_bytes) <= head_count;
   assign pop       = dec_valid && dec_ready;
   assign pop_len   = length;

   assign dec_opcode      = opc;
   assign dec_modrm       = use_modrm ? modrm : 8'h00;
   assign dec_has_modrm   = use_modrm;
   assign dec_illegal     = illegal;
   assign dec_length      = length;
   assign dec_size        = size;
   assign dec_disp_bytes  = disp_bytes;
   assign dec_imm_bytes   = imm_bytes;
   // bytes beyond disp plus imm are masked off by the separator
   assign dec_field_bytes = FIELD_W'(head_window >> {field_ofs, 3'b000});

endmodule

// File: logic/inst_byte_queue.sv
`timescale 1ns/1ps

module inst_byte_queue import decode_pkg::*; #(
   parameter int QUEUE_BYTES = 32
) (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      fetch_valid,
   input  logic [8*FETCH_BYTES-1:0]  fetch_bytes,
   output logic                      fetch_ready,
   output logic [8*WINDOW_BYTES-1:0] head_window,
   output logic [CNT_W-1:0]          head_count,
   input  logic                      pop,
   input  logic [LEN_W-1:0]          pop_len
);

   localparam int PTR_W = $clog2(QUEUE_BYTES);
   localparam int OCC_W = $clog2(QUEUE_BYTES + 1);

   logic [7:0]       mem [QUEUE_BYTES];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [OCC_W-1:0] occ;
   logic             push;
   logic [OCC_W-1:0] add_cnt;
   logic [OCC_W-1:0] sub_cnt;

   // room for a whole beat
   assign fetch_ready = occ <= OCC_W'(QUEUE_BYTES - FETCH_BYTES);
   assign push        = fetch_valid && fetch_ready;

   assign add_cnt = push ? OCC_W'(FETCH_BYTES) : '0;
   assign sub_cnt = pop ? OCC_W'(pop_len) : '0;

   // byte 0 of the beat lands at the write pointer
   always_ff @(posedge clk) begin
      if (push) begin
         for (int i = 0; i < FETCH_BYTES; i++) begin
            mem[wr_ptr + PTR_W'(i)] <= fetch_bytes[8*i +: 8];
         end
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         occ    <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + PTR_W'(FETCH_BYTES);
         end
         if (pop) begin
            rd_ptr <= rd_ptr + PTR_W'(pop_len);
         end
         // push and pop may land on the same edge
         occ <= occ + add_cnt - sub_cnt;
      end
   end

   // rotated read, bytes at or past head_count are stale
   always_comb begin
      for (int i = 0; i < WINDOW_BYTES; i++) begin
         head_window[8*i +: 8] = mem[rd_ptr + PTR_W'(i)];
      end
   end

   // decoder only needs to know whether the window is full
   assign head_count = (occ > OCC_W'(WINDOW_BYTES)) ? CNT_W'(WINDOW_BYTES) : CNT_W'(occ);

endmodule

// File: logic/decode_pkg.sv
package decode_pkg;

   // opcode and prefix bytes of the supported subset
   parameter logic [7:0] OPC_ADD_AL_IB  = 8'h04;
   parameter logic [7:0] OPC_ADD_EAX_IZ = 8'h05;
   parameter logic [7:0] OPC_GRP1_EB_IB = 8'h80;
   parameter logic [7:0] OPC_GRP1_EV_IZ = 8'h81;
   parameter logic [7:0] OPC_GRP1_EV_IB = 8'h83;
   parameter logic [7:0] OPC_ADD_EV_GV  = 8'h01;
   parameter logic [7:0] OPC_ADD_GV_EV  = 8'h03;
   parameter logic [7:0] OPC_JMP_FAR    = 8'hEA;
   parameter logic [7:0] OPC_NOP        = 8'h90;
   parameter logic [7:0] PFX_OPSIZE     = 8'h66;

   // prefix, opcode, modrm, sib, 4 disp bytes and 6 imm bytes
   parameter int MAX_INST_BYTES = 14;

   // bytes the decoder can look at in one cycle
   parameter int WINDOW_BYTES = 16;

   // one fetch beat
   parameter int FETCH_BYTES = 8;

   // output field widths
   parameter int IMM_W  = 48;
   parameter int DISP_W = 32;

   // displacement bytes followed by immediate bytes
   parameter int FIELD_W = DISP_W + IMM_W;

   // instruction length, saturated window count and field byte count
   parameter int LEN_W  = $clog2(MAX_INST_BYTES + 1);
   parameter int CNT_W  = $clog2(WINDOW_BYTES + 1);
   parameter int FCNT_W = 3;

   // SIZE_48 only shows up on the far pointer
   typedef enum logic [1:0] {
      SIZE_8  = 2'd0,
      SIZE_16 = 2'd1,
      SIZE_32 = 2'd2,
      SIZE_48 = 2'd3
   } op_size_e;

endpackage
